// ==== sources.f ====
+incdir+common
+incdir+verif
common/ccPkg.sv
common/exploreIf.sv
hdl/firstBitFinder.sv
explorer/latticeClosure.sv
explorer/explorationStep.sv
hdl/countController.sv
hdl/countConnectedTop.sv
verif/tbCountConnected.sv

// ==== verif/ccRefModel.svh ====
`ifndef CC_REF_MODEL_SVH
`define CC_REF_MODEL_SVH

// Every superset of each set element, walked as (s + 1) | i
function automatic graphT closeUpward(input graphT g);
    graphT r;
    int s;
    r = '0;
    for (int i = 0; i < `CC_GRAPH_BITS; i++) begin
        if (g[i]) begin
            s = i;
            r[s] = 1'b1;
            while (s != `CC_GRAPH_BITS - 1) begin
                s = (s + 1) | i;
                r[s] = 1'b1;
            end
        end
    end
    return r;
endfunction

// Every subset of each set element, walked as (s - 1) & j
function automatic graphT closeDownward(input graphT g);
    graphT r;
    int s;
    r = '0;
    for (int j = 0; j < `CC_GRAPH_BITS; j++) begin
        if (g[j]) begin
            s = j;
            r[s] = 1'b1;
            while (s != 0) begin
                s = (s - 1) & j;
                r[s] = 1'b1;
            end
        end
    end
    return r;
endfunction

function automatic int countComponents(input graphT g);
    graphT left;
    graphT ext;
    graphT nxt;
    int n;
    left = g;
    n = 0;
    while (left != '0) begin
        // Lowest set bit seeds the next component
        ext = left & (~left + 1'b1);
        nxt = left & closeDownward(left & closeUpward(ext));
        while (nxt != ext) begin
            ext = nxt;
            nxt = left & closeDownward(left & closeUpward(ext));
        end
        left = left & ~ext;
        n++;
    end
    return n;
endfunction

`endif

// ==== verif/tbCountConnected.sv ====
`timescale 1ns/1ps
`include "cc_config.svh"

module tbCountConnected;
    import ccPkg::*;

    `include "ccRefModel.svh"

    localparam int WaitLimit = 20000;
    localparam int RandomGraphs = 50;
    localparam int TotalGraphs = RandomGraphs + 4;

    logic  clk;
    logic  arstN;
    logic  request;
    graphT graphIn;
    logic  graphInAvailable;
    tagT   tagIn;
    logic  done;
    countT connectCount;
    tagT   tagOut;

    // Expected result of the graph in flight
    string curTest;
    int    expCount;
    int    expTag;
    int    acceptCount;
    int    doneCount;

    logic [15:0] lfsr;

    countConnectedTop UUT (
        .clk              (clk),
        .arstN            (arstN),
        .request          (request),
        .graphIn          (graphIn),
        .graphInAvailable (graphInAvailable),
        .tagIn            (tagIn),
        .done             (done),
        .connectCount     (connectCount),
        .tagOut           (tagOut)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic reportMismatch(input string test, input string what, input int exp,
                                  input int act);
        abortRun($sformatf("[ERROR] %s: %s expected %0d, actual %0d", test, what, exp, act));
    endtask

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] stepLfsr(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic drawBits(input int count, output graphT bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = stepLfsr(lfsr);
            bits[i] = lfsr[0];
        end
    endtask

    task automatic waitForRequest(input string name);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!request && cycles < WaitLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (!request) begin
            abortRun($sformatf("Timed out waiting for request before test %s, controller in %s",
                               name, UUT.controller.state.name()));
        end
    endtask

    task automatic waitForDone(input string name);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!done && cycles < WaitLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            abortRun($sformatf("Timed out waiting for done in test %s, controller in %s",
                               name, UUT.controller.state.name()));
        end
    endtask

    // Offer stays up while the graph is processed, so a second take would show
    task automatic offerGraph(input string name, input graphT g, input tagT t,
                              input int expected);
        waitForRequest(name);
        curTest = name;
        expCount = expected;
        expTag = t;
        graphIn <= g;
        tagIn <= t;
        graphInAvailable <= 1'b1;
        waitForDone(name);
        graphInAvailable <= 1'b0;
    endtask

    always @(posedge clk) begin
        if (arstN && request && graphInAvailable) begin
            assert (acceptCount == doneCount)
                else abortRun("A graph was accepted while another was still in flight");
            acceptCount++;
        end
    end

    always @(posedge clk) begin
        if (arstN && done) begin
            assert (doneCount < acceptCount)
                else abortRun("done was raised with no accepted graph");
            doneCount++;
            assert (connectCount == expCount)
                else reportMismatch(curTest, "count", expCount, connectCount);
            assert (tagOut == expTag)
                else reportMismatch(curTest, "tag", expTag, tagOut);
        end
    end

    doneExcludesRequest: assert property (@(posedge clk) disable iff (!arstN)
        done |-> !request)
        else abortRun("done was raised while request was high");

    acceptDropsRequest: assert property (@(posedge clk) disable iff (!arstN)
        (request && graphInAvailable) |=> !request)
        else abortRun("request stayed high after a graph was accepted");

    requestFollowsDone: assert property (@(posedge clk) disable iff (!arstN)
        $rose(request) |-> $past(done))
        else abortRun("request returned high without a preceding done");

    initial begin
        graphT antichain;
        graphT g;
        graphT mask;
        graphT bits;
        acceptCount = 0;
        doneCount = 0;
        expCount = 0;
        expTag = 0;
        curTest = "reset";
        lfsr = 16'd36854;
        arstN = 1'b0;
        graphIn = '0;
        graphInAvailable = 1'b0;
        tagIn = '0;
        repeat (8) @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);
        assert (request == 1'b1) else reportMismatch("reset", "request", 1, request);
        assert (done == 1'b0) else reportMismatch("reset", "done", 0, done);

        offerGraph("emptyGraph", '0, 10'h155, 0);
        offerGraph("singleBit", graphT'(1) << 37, 10'h2a3, 1);
        offerGraph("allOnes", '1, 10'h3ff, 1);

        // All 3-variable elements are pairwise incomparable
        antichain = '0;
        for (int i = 0; i < `CC_GRAPH_BITS; i++) begin
            antichain[i] = ($countones(i) == 3);
        end
        offerGraph("antichain3", antichain, 10'h023, 35);

        for (int i = 0; i < RandomGraphs; i++) begin
            drawBits(`CC_GRAPH_BITS, g);
            for (int w = 1; w < 2 + (i % 3); w++) begin
                drawBits(`CC_GRAPH_BITS, mask);
                g = g & mask;
            end
            drawBits(`CC_TAG_BITS, bits);
            offerGraph($sformatf("random%0d", i), g, bits[`CC_TAG_BITS-1:0],
                       countComponents(g));
        end

        @(posedge clk);
        if (doneCount == TotalGraphs && acceptCount == TotalGraphs) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            abortRun($sformatf("Expected %0d results, saw %0d accepted and %0d done",
                               TotalGraphs, acceptCount, doneCount));
        end
    end

endmodule

// ==== hdl/countConnectedTop.sv ====
`timescale 1ns/1ps

module countConnectedTop (
    input  logic         clk,
    input  logic         arstN,
    output logic         request,
    input  ccPkg::graphT graphIn,
    input  logic         graphInAvailable,
    input  ccPkg::tagT   tagIn,
    output logic         done,
    output ccPkg::countT connectCount,
    output ccPkg::tagT   tagOut
);
    import ccPkg::*;

    graphT leftoverGraph;
    graphT seed;
    logic  nonEmpty;

    exploreIf exIf ();

    countController controller (
        .clk              (clk),
        .arstN            (arstN),
        .request          (request),
        .graphIn          (graphIn),
        .graphInAvailable (graphInAvailable),
        .tagIn            (tagIn),
        .seed             (seed),
        .nonEmpty         (nonEmpty),
        .leftoverGraph    (leftoverGraph),
        .ex               (exIf),
        .done             (done),
        .connectCount     (connectCount),
        .tagOut           (tagOut)
    );

    // Seed for the next component
    firstBitFinder seedFinder (
        .graph    (leftoverGraph),
        .seed     (seed),
        .nonEmpty (nonEmpty)
    );

    explorationStep stepUnit (
        .clk   (clk),
        .arstN (arstN),
        .ex    (exIf)
    );

endmodule

// ==== hdl/countController.sv ====
`timescale 1ns/1ps

module countController (
    input  logic         clk,
    input  logic         arstN,
    output logic         request,
    input  ccPkg::graphT graphIn,
    input  logic         graphInAvailable,
    input  ccPkg::tagT   tagIn,
    input  ccPkg::graphT seed,
    input  logic         nonEmpty,
    output ccPkg::graphT leftoverGraph,
    exploreIf.controller ex,
    output logic         done,
    output ccPkg::countT connectCount,
    output ccPkg::tagT   tagOut
);
    import ccPkg::*;

    ctrlStateT state;
    graphT     leftover;
    graphT     extending;
    countT     count;
    tagT       tag;

    logic accept;

    assign request = (state == stIdle);
    assign accept  = request && graphInAvailable;

    assign leftoverGraph = leftover;
    assign ex.leftover   = leftover;
    assign ex.extending  = extending;

    // Control path
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= stIdle;
            ex.start <= 1'b0;
            done     <= 1'b0;
        end else begin
            ex.start <= 1'b0;
            done     <= 1'b0;
            case (state)
                stIdle: begin
                    if (accept) begin
                        state <= stSeed;
                    end
                end
                stSeed: begin
                    if (nonEmpty) begin
                        ex.start <= 1'b1;
                        state    <= stExplore;
                    end else begin
                        // Nothing left so the count is final
                        done  <= 1'b1;
                        state <= stReport;
                    end
                end
                stExplore: begin
                    if (ex.resultValid) begin
                        if (ex.finished) begin
                            state <= stSeed;
                        end else begin
                            ex.start <= 1'b1;
                        end
                    end
                end
                stReport: begin
                    state <= stIdle;
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // Graph, count and tag
    always_ff @(posedge clk) begin
        case (state)
            stIdle: begin
                if (accept) begin
                    leftover <= graphIn;
                    tag      <= tagIn;
                    count    <= '0;
                end
            end
            stSeed: begin
                if (nonEmpty) begin
                    extending <= seed;
                end else begin
                    connectCount <= count;
                    tagOut       <= tag;
                end
            end
            stExplore: begin
                if (ex.resultValid) begin
                    if (ex.finished) begin
                        // Completed component leaves the graph
                        leftover <= ex.reduced;
                        count    <= count + 1'b1;
                    end else begin
                        extending <= ex.extended;
                    end
                end
            end
            default: begin
            end
        endcase
    end

    // A result is only reported once the graph is used up
    doneNotIdle: assert property (@(posedge clk) disable iff (!arstN)
        done |-> !request && leftover == '0)
        else $error("done raised while request is high or the graph is not empty");

endmodule

// ==== explorer/explorationStep.sv ====
`timescale 1ns/1ps

module explorationStep (
    input logic          clk,
    input logic          arstN,
    exploreIf.explorer   ex
);
    import ccPkg::*;

    graphT upClosed;
    graphT midPoint;
    graphT downClosed;

    // Request payload aligned with the closure stages
    graphT leftoverD1;
    graphT leftoverD2;
    graphT extendingD1;
    graphT extendingD2;

    logic validD1;
    logic validD2;

    // Stage 1
    latticeClosure #(.UP(1'b1)) upClosure (
        .clk      (clk),
        .arstN    (arstN),
        .graphIn  (ex.extending),
        .graphOut (upClosed)
    );

    // Stage 2 on the part of the upward closure still in the graph
    assign midPoint = upClosed & leftoverD1;

    latticeClosure #(.UP(1'b0)) downClosure (
        .clk      (clk),
        .arstN    (arstN),
        .graphIn  (midPoint),
        .graphOut (downClosed)
    );

    always_ff @(posedge clk) begin
        leftoverD1  <= ex.leftover;
        leftoverD2  <= leftoverD1;
        extendingD1 <= ex.extending;
        extendingD2 <= extendingD1;
    end

    // Stage 3 splits the leftover graph
    always_ff @(posedge clk) begin
        ex.extended <= leftoverD2 & downClosed;
        ex.reduced  <= leftoverD2 & ~downClosed;
        ex.finished <= (leftoverD2 & downClosed) == extendingD2;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validD1        <= 1'b0;
            validD2        <= 1'b0;
            ex.resultValid <= 1'b0;
        end else begin
            validD1        <= ex.start;
            validD2        <= validD1;
            ex.resultValid <= validD2;
        end
    end

    // Only one step may be in flight
    singleInFlight: assert property (@(posedge clk) disable iff (!arstN)
        ex.start |=> !ex.start ##1 !ex.start ##1 !ex.start)
        else $error("start issued while a step was still in flight");

    // Neither the old nor the new extension may land in the reduced graph
    splitDisjoint: assert property (@(posedge clk) disable iff (!arstN)
        ex.resultValid |-> ((ex.extended | $past(ex.extending, 3)) & ex.reduced) == '0)
        else $error("reduced overlaps the extension");

endmodule

// ==== explorer/latticeClosure.sv ====
`timescale 1ns/1ps
`include "cc_config.svh"

module latticeClosure #(
    // 1 closes towards supersets, 0 towards subsets
    parameter bit UP = 1'b1
) (
    input  logic         clk,
    input  logic         arstN,
    input  ccPkg::graphT graphIn,
    output ccPkg::graphT graphOut
);
    import ccPkg::*;

    localparam int Vars = `CC_VARS;
    localparam int Bits = `CC_GRAPH_BITS;

    graphT closed;

    // One pass per variable, each pass moves bits across that variable only,
    // so the partner bits read in a pass are never written by the same pass
    always_comb begin
        closed = graphIn;
        for (int v = 0; v < Vars; v++) begin
            for (int i = 0; i < Bits; i++) begin
                if (((i >> v) & 1) == int'(UP)) begin
                    closed[i] = closed[i] | closed[i ^ (1 << v)];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            graphOut <= '0;
        end else begin
            graphOut <= closed;
        end
    end

endmodule

// ==== hdl/firstBitFinder.sv ====
`timescale 1ns/1ps
`include "cc_config.svh"

module firstBitFinder (
    input  ccPkg::graphT graph,
    output ccPkg::graphT seed,
    output logic         nonEmpty
);
    localparam int Bits = `CC_GRAPH_BITS;
    localparam int Nibbles = Bits / 4;
    localparam int Groups = Bits / 16;

    logic [Nibbles-1:0] hasBit4;
    logic [Groups-1:0]  hasBit16;
    logic [1:0]         hasBit64;

    // Lowest occupied nibble within each 16-bit group
    logic [Nibbles-1:0] firstBit4;
    // Lowest occupied 16-bit group within each half
    logic [Groups-1:0]  firstBit16;
    logic [1:0]         firstBit64;

    function automatic logic [3:0] lowestOf4(input logic [3:0] v);
        lowestOf4 = {v[3] & ~|v[2:0], v[2] & ~|v[1:0], v[1] & ~v[0], v[0]};
    endfunction

    always_comb begin
        for (int n = 0; n < Nibbles; n++) begin
            hasBit4[n] = |graph[4*n +: 4];
        end
        for (int g = 0; g < Groups; g++) begin
            hasBit16[g] = |hasBit4[4*g +: 4];
            firstBit4[4*g +: 4] = lowestOf4(hasBit4[4*g +: 4]);
        end
        for (int h = 0; h < 2; h++) begin
            hasBit64[h] = |hasBit16[4*h +: 4];
            firstBit16[4*h +: 4] = lowestOf4(hasBit16[4*h +: 4]);
        end
        // The upper half only counts when the lower half is empty
        firstBit64 = {hasBit64[1] & ~hasBit64[0], hasBit64[0]};
        for (int n = 0; n < Nibbles; n++) begin
            seed[4*n +: 4] = lowestOf4(graph[4*n +: 4])
                & {4{firstBit4[n] & firstBit16[n/4] & firstBit64[n/16]}};
        end
        nonEmpty = |hasBit64;
    end

    // Seed is a single graph bit with no set graph bit below it
    always_comb begin
        assert final ($onehot0(seed) && ((seed != '0) == nonEmpty)
                      && ((seed & graph) == seed)
                      && (((seed - 1'b1) & graph) == '0))
            else $error("firstBitFinder seed is not the lowest set bit");
    end

endmodule

// ==== common/exploreIf.sv ====
`timescale 1ns/1ps

interface exploreIf;
    import ccPkg::*;

    // Request side, sampled in the start cycle only
    logic  start;
    graphT extending;
    graphT leftover;

    // Result side, valid with the resultValid pulse
    logic  resultValid;
    graphT extended;
    graphT reduced;
    logic  finished;

    modport controller (
        output start, extending, leftover,
        input  resultValid, extended, reduced, finished
    );

    modport explorer (
        input  start, extending, leftover,
        output resultValid, extended, reduced, finished
    );

endinterface

// ==== common/ccPkg.sv ====
`include "cc_config.svh"

package ccPkg;

    // Bit index is the variable set of the lattice element
    typedef logic [`CC_GRAPH_BITS-1:0] graphT;

    typedef logic [`CC_COUNT_BITS-1:0] countT;

    typedef logic [`CC_TAG_BITS-1:0] tagT;

    // Controller FSM states
    typedef enum logic [1:0] {
        stIdle,
        stSeed,
        stExplore,
        stReport
    } ctrlStateT;

endpackage

// ==== common/cc_config.svh ====
`ifndef CC_CONFIG_SVH
`define CC_CONFIG_SVH

// Variables of the Boolean lattice
`define CC_VARS 7

// One bit per lattice element, 2 ** CC_VARS
`define CC_GRAPH_BITS 128

// Largest antichain of the 7-variable lattice is 35
`define CC_COUNT_BITS 6

`define CC_TAG_BITS 10

`endif
